//--- hw/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// window geometry
`define CONV_K          5
`define CONV_COL_ADDRS  32     // reads per band, last 4 are padding
`define CONV_IMG_COLS   28     // real image columns
`define CONV_OUT_COLS   24     // windows per band

// sweep size
`define CONV_BANDS      8      // 12 rows, 5-row window
`define CONV_KERNELS    2

// data widths
`define CONV_W_WIDTH    8
`define CONV_B_WIDTH    8
`define CONV_ACT_WIDTH  16

`endif

//--- hw/conv_pkg.sv
`include "conv_consts.svh"

package conv_pkg;

    typedef logic [4:0]                         col_addr_t;    // 0..31 within a band
    typedef logic [4:0]                         band_t;
    typedef logic [4:0]                         kernel_t;
    typedef logic [8:0]                         param_addr_t;  // kernel*5 + weight column

    // bit i holds image row band+i
    typedef logic [`CONV_K-1:0]                 pix_col_t;

    typedef logic signed [`CONV_W_WIDTH-1:0]    weight_t;
    typedef logic signed [`CONV_B_WIDTH-1:0]    bias_t;
    typedef logic signed [`CONV_ACT_WIDTH-1:0]  sum_t;
    typedef logic [`CONV_ACT_WIDTH-1:0]         act_t;         // after relu

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,      // weight columns of one kernel
        SEQ_SWEEP      // all bands of that kernel
    } seq_state_t;

endpackage

//--- hw/conv_decode.sv
`include "conv_consts.svh"

module conv_decode (
    input  logic                   sclk,
    input  logic                   s_rst_n,
    input  logic                   cal_start,
    output logic                   busy,
    output conv_pkg::col_addr_t    data_rd_addr,
    output conv_pkg::band_t        row_cnt,
    output conv_pkg::param_addr_t  param_rd_addr,
    output conv_pkg::kernel_t      bias_rd_addr,
    output logic                   load_en,
    output logic [2:0]             load_col,
    output logic                   tag_vld
);
    import conv_pkg::*;

    seq_state_t  state;
    kernel_t     kernel;
    logic [2:0]  ld_cnt;    // 0..4 reads, 5 is the last capture
    logic [2:0]  ld_col;

    assign ld_col        = (ld_cnt > 3'(`CONV_K - 1)) ? 3'(`CONV_K - 1) : ld_cnt;
    assign param_rd_addr = param_addr_t'(kernel) * param_addr_t'(`CONV_K) + param_addr_t'(ld_col);
    assign bias_rd_addr  = kernel;    // bias settles during the load phase
    assign busy          = (state != SEQ_IDLE);

    always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
            state        <= SEQ_IDLE;
            kernel       <= '0;
            ld_cnt       <= '0;
            data_rd_addr <= '0;
            row_cnt      <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (cal_start) begin    // pulses while busy never reach here
                        state        <= SEQ_LOAD;
                        kernel       <= '0;
                        ld_cnt       <= '0;
                        data_rd_addr <= '0;
                        row_cnt      <= '0;
                    end
                end
                SEQ_LOAD: begin
                    if (ld_cnt == 3'(`CONV_K)) begin
                        state  <= SEQ_SWEEP;
                        ld_cnt <= '0;
                    end else begin
                        ld_cnt <= ld_cnt + 3'd1;
                    end
                end
                SEQ_SWEEP: begin
                    data_rd_addr <= data_rd_addr + col_addr_t'(1);    // wraps 31 -> 0
                    if (data_rd_addr == col_addr_t'(`CONV_COL_ADDRS - 1)) begin
                        if (row_cnt == band_t'(`CONV_BANDS - 1)) begin
                            row_cnt <= '0;
                            if (kernel == kernel_t'(`CONV_KERNELS - 1)) begin
                                state <= SEQ_IDLE;
                            end else begin
                                kernel <= kernel + kernel_t'(1);
                                state  <= SEQ_LOAD;
                            end
                        end else begin
                            row_cnt <= row_cnt + band_t'(1);
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // strobes line up with the one-cycle memory read
    always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
            load_en  <= 1'b0;
            load_col <= '0;
            tag_vld  <= 1'b0;
        end else begin
            load_en  <= (state == SEQ_LOAD) && (ld_cnt < 3'(`CONV_K));
            load_col <= ld_cnt;
            tag_vld  <= (state == SEQ_SWEEP)
                        && (data_rd_addr >= col_addr_t'(`CONV_K - 1))
                        && (data_rd_addr <= col_addr_t'(`CONV_IMG_COLS - 1));
        end
    end

    // every sweep starts at column 0
    a_addr_start: assert property (@(posedge sclk) disable iff (!s_rst_n)
        (state != SEQ_SWEEP) |-> data_rd_addr == '0);

    a_band_range: assert property (@(posedge sclk) disable iff (!s_rst_n)
        row_cnt < band_t'(`CONV_BANDS));

endmodule

//--- hw/conv_execute.sv
`include "conv_consts.svh"

module conv_execute (
    input  logic                sclk,
    input  logic                s_rst_n,
    input  conv_pkg::pix_col_t  col_data,
    input  conv_pkg::weight_t   param_w_h0,
    input  conv_pkg::weight_t   param_w_h1,
    input  conv_pkg::weight_t   param_w_h2,
    input  conv_pkg::weight_t   param_w_h3,
    input  conv_pkg::weight_t   param_w_h4,
    input  logic                load_en,
    input  logic [2:0]          load_col,
    input  logic                tag_vld,
    output conv_pkg::sum_t      sum,
    output logic                sum_vld
);
    import conv_pkg::*;

    weight_t   w_in   [`CONV_K];                // one weight column from the rom
    weight_t   w_bank [`CONV_K][`CONV_K];       // [row][col]
    pix_col_t  hist   [`CONV_K-1];              // hist[0] is the oldest slice
    pix_col_t  win    [`CONV_K];
    sum_t      acc;

    assign w_in[0] = param_w_h0;
    assign w_in[1] = param_w_h1;
    assign w_in[2] = param_w_h2;
    assign w_in[3] = param_w_h3;
    assign w_in[4] = param_w_h4;

    // weight bank, written one column per load strobe
    always_ff @(posedge sclk) begin
        if (load_en) begin
            for (int r = 0; r < `CONV_K; r++) begin
                w_bank[r][load_col] <= w_in[r];
            end
        end
    end

    // slice history, new data enters at the top
    always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
            for (int c = 0; c < `CONV_K - 1; c++) begin
                hist[c] <= '0;
            end
        end else begin
            for (int c = 0; c < `CONV_K - 2; c++) begin
                hist[c] <= hist[c+1];
            end
            hist[`CONV_K-2] <= col_data;
        end
    end

    // the landing slice is the newest window column
    always_comb begin
        for (int c = 0; c < `CONV_K - 1; c++) begin
            win[c] = hist[c];
        end
        win[`CONV_K-1] = col_data;
    end

    // binary pixels select weights, no multiplier needed
    always_comb begin
        acc = '0;
        for (int c = 0; c < `CONV_K; c++) begin
            for (int r = 0; r < `CONV_K; r++) begin
                if (win[c][r]) begin
                    acc = acc + sum_t'(w_bank[r][c]);
                end
            end
        end
    end

    always_ff @(posedge sclk) begin
        sum <= acc;
    end

    always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
            sum_vld <= 1'b0;
        end else begin
            sum_vld <= tag_vld;    // tag rides along with the sum
        end
    end

endmodule

//--- hw/conv_result.sv
module conv_result (
    input  logic            sclk,
    input  logic            s_rst_n,
    input  conv_pkg::sum_t  sum,
    input  logic            sum_vld,
    input  conv_pkg::bias_t param_bias,
    output conv_pkg::act_t  conv_rslt_act,
    output logic            conv_rslt_act_vld
);
    import conv_pkg::*;

    sum_t  biased;

    // bias is sign extended to the sum width
    assign biased = sum + sum_t'(param_bias);

    // relu, result only moves on a valid sum
    always_ff @(posedge sclk) begin
        if (sum_vld) begin
            if (biased[$bits(sum_t)-1]) begin
                conv_rslt_act <= '0;
            end else begin
                conv_rslt_act <= act_t'(biased);
            end
        end
    end

    always_ff @(posedge sclk or negedge s_rst_n) begin
        if (!s_rst_n) begin
            conv_rslt_act_vld <= 1'b0;
        end else begin
            conv_rslt_act_vld <= sum_vld;
        end
    end

    a_relu_nonneg: assert property (@(posedge sclk) disable iff (!s_rst_n)
        conv_rslt_act_vld |-> !conv_rslt_act[$bits(act_t)-1]);

endmodule

//--- hw/conv_top.sv
module conv_top (
    input  logic                   sclk,
    input  logic                   s_rst_n,
    input  logic                   cal_start,
    output logic                   busy,
    output conv_pkg::col_addr_t    data_rd_addr,
    output conv_pkg::band_t        row_cnt,
    input  conv_pkg::pix_col_t     col_data,
    output conv_pkg::param_addr_t  param_rd_addr,
    input  conv_pkg::weight_t      param_w_h0,
    input  conv_pkg::weight_t      param_w_h1,
    input  conv_pkg::weight_t      param_w_h2,
    input  conv_pkg::weight_t      param_w_h3,
    input  conv_pkg::weight_t      param_w_h4,
    output conv_pkg::kernel_t      bias_rd_addr,
    input  conv_pkg::bias_t        param_bias,
    output conv_pkg::act_t         conv_rslt_act,
    output logic                   conv_rslt_act_vld
);
    import conv_pkg::*;

    logic        load_en;
    logic [2:0]  load_col;
    logic        tag_vld;
    sum_t        sum;
    logic        sum_vld;

    conv_decode u_decode (
        .sclk          (sclk),
        .s_rst_n       (s_rst_n),
        .cal_start     (cal_start),
        .busy          (busy),
        .data_rd_addr  (data_rd_addr),
        .row_cnt       (row_cnt),
        .param_rd_addr (param_rd_addr),
        .bias_rd_addr  (bias_rd_addr),
        .load_en       (load_en),
        .load_col      (load_col),
        .tag_vld       (tag_vld)
    );

    conv_execute u_execute (
        .sclk       (sclk),
        .s_rst_n    (s_rst_n),
        .col_data   (col_data),
        .param_w_h0 (param_w_h0),
        .param_w_h1 (param_w_h1),
        .param_w_h2 (param_w_h2),
        .param_w_h3 (param_w_h3),
        .param_w_h4 (param_w_h4),
        .load_en    (load_en),
        .load_col   (load_col),
        .tag_vld    (tag_vld),
        .sum        (sum),
        .sum_vld    (sum_vld)
    );

    conv_result u_result (
        .sclk              (sclk),
        .s_rst_n           (s_rst_n),
        .sum               (sum),
        .sum_vld           (sum_vld),
        .param_bias        (param_bias),
        .conv_rslt_act     (conv_rslt_act),
        .conv_rslt_act_vld (conv_rslt_act_vld)
    );

endmodule

//--- test/tb_conv.sv
`include "conv_consts.svh"

module tb_conv;
    timeunit 1ns;
    timeprecision 100ps;
    import conv_pkg::*;

    localparam int IMG_ROWS    = `CONV_BANDS + `CONV_K - 1;
    localparam int PER_KERNEL  = `CONV_BANDS * `CONV_OUT_COLS;
    localparam int STIM_WORDS  = IMG_ROWS + 8 * `CONV_KERNELS;
    localparam int RUN_CYCLES  = `CONV_KERNELS * (`CONV_BANDS * `CONV_COL_ADDRS + 6);
    localparam int CYCLE_LIMIT = 2 * RUN_CYCLES + 100;
    localparam int POKE_CYCLE  = 300;    // well inside the sweep

    logic         sclk = 1'b0;
    logic         s_rst_n = 1'b0;
    logic         cal_start = 1'b0;
    logic         busy;
    col_addr_t    data_rd_addr;
    band_t        row_cnt;
    pix_col_t     col_data = '0;
    param_addr_t  param_rd_addr;
    weight_t      param_w_h0 = '0;
    weight_t      param_w_h1 = '0;
    weight_t      param_w_h2 = '0;
    weight_t      param_w_h3 = '0;
    weight_t      param_w_h4 = '0;
    kernel_t      bias_rd_addr;
    bias_t        param_bias = '0;
    act_t         conv_rslt_act;
    logic         conv_rslt_act_vld;

    logic [39:0]  stim [STIM_WORDS];
    logic [31:0]  img_rows [IMG_ROWS];                       // bit c is image column c
    weight_t      wts [`CONV_KERNELS][`CONV_K][`CONV_K];    // [kernel][row][col]
    bias_t        biases [`CONV_KERNELS];
    sum_t         exp_total [`CONV_KERNELS];
    int           exp_nonzero [`CONV_KERNELS];
    int           value_errs = 0;
    int           other_errs = 0;
    int           cycles = 0;

    conv_top u_dut (.*);

    always #20 sclk = ~sclk;

    function automatic pix_col_t image_slice(int band, int col);
        pix_col_t s;
        for (int i = 0; i < `CONV_K; i++) begin
            s[i] = img_rows[band + i][col];
        end
        return s;
    endfunction

    function automatic weight_t rom_weight(int addr, int r);
        return wts[addr / `CONV_K][r][addr % `CONV_K];    // addr = kernel*5 + column
    endfunction

    // image ram and parameter rom, one cycle read latency
    always @(posedge sclk) begin
        col_data   <= image_slice(int'(row_cnt), int'(data_rd_addr));
        param_w_h0 <= rom_weight(int'(param_rd_addr), 0);
        param_w_h1 <= rom_weight(int'(param_rd_addr), 1);
        param_w_h2 <= rom_weight(int'(param_rd_addr), 2);
        param_w_h3 <= rom_weight(int'(param_rd_addr), 3);
        param_w_h4 <= rom_weight(int'(param_rd_addr), 4);
        param_bias <= biases[int'(bias_rd_addr)];
    end

    // relu of bias plus the weights under set pixels
    function automatic act_t expected_act(int k, int b, int x);
        int acc;
        acc = int'(biases[k]);
        for (int c = 0; c < `CONV_K; c++) begin
            for (int r = 0; r < `CONV_K; r++) begin
                if (img_rows[b + r][x + c]) begin
                    acc += int'(wts[k][r][c]);
                end
            end
        end
        if (acc < 0) begin
            acc = 0;
        end
        return act_t'(acc);
    endfunction

    task automatic check_act(input act_t got, input act_t want, input string what);
        if (got !== want) begin
            value_errs++;
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_sum(input sum_t got, input sum_t want, input string what);
        if (got !== want) begin
            value_errs++;
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        if (got != want) begin
            value_errs++;
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // one run, from the cal_start pulse until busy drops
    task automatic run_sweep(input bit poke_midway);
        int  res_idx;
        int  k;
        int  cyc;
        bit  prev_vld;
        bit  seen_busy;
        int  total [`CONV_KERNELS];
        int  nonzero [`CONV_KERNELS];
        res_idx   = 0;
        cyc       = 0;
        prev_vld  = 1'b0;
        seen_busy = 1'b0;
        for (int i = 0; i < `CONV_KERNELS; i++) begin
            total[i]   = 0;
            nonzero[i] = 0;
        end
        @(posedge sclk);
        cal_start <= 1'b1;
        while (!(seen_busy && !busy)) begin
            @(posedge sclk);
            cal_start <= poke_midway && (cyc == POKE_CYCLE);    // stray pulse while busy
            @(negedge sclk);
            cyc++;
            if (busy) begin
                seen_busy = 1'b1;
            end
            if ((conv_rslt_act_vld != prev_vld) && (res_idx % `CONV_OUT_COLS != 0)) begin
                other_errs++;
                $display("results of one band are not on consecutive cycles at %0t ns", $time);
            end
            prev_vld = conv_rslt_act_vld;
            if (conv_rslt_act_vld) begin
                if (conv_rslt_act[$bits(act_t)-1]) begin
                    other_errs++;
                    $display("negative result seen at %0t ns", $time);
                end
                if (res_idx >= `CONV_KERNELS * PER_KERNEL) begin
                    other_errs++;
                    $display("more results than windows in one run at %0t ns", $time);
                end else begin
                    k = res_idx / PER_KERNEL;
                    check_act(conv_rslt_act,
                              expected_act(k, (res_idx / `CONV_OUT_COLS) % `CONV_BANDS,
                                           res_idx % `CONV_OUT_COLS),
                              $sformatf("result %0d of kernel %0d", res_idx % PER_KERNEL, k));
                    total[k] += int'(conv_rslt_act);
                    if (conv_rslt_act != '0) begin
                        nonzero[k]++;
                    end
                end
                res_idx++;
            end
        end
        repeat (4) begin
            @(negedge sclk);
            if (conv_rslt_act_vld) begin
                other_errs++;
                $display("result valid is high after busy fell at %0t ns", $time);
            end
        end
        check_count(res_idx, `CONV_KERNELS * PER_KERNEL, "results in one run");
        for (int i = 0; i < `CONV_KERNELS; i++) begin
            check_sum(sum_t'(total[i]), exp_total[i], $sformatf("result total of kernel %0d", i));
            check_count(nonzero[i], exp_nonzero[i], $sformatf("nonzero results of kernel %0d", i));
        end
    endtask

    initial begin
        int gap;
        void'($urandom(32'h793));
        gap = 2 + int'($urandom() % 8);    // idle time before the first start
        $readmemh("test/conv_stimulus.txt", stim);
        for (int r = 0; r < IMG_ROWS; r++) begin
            img_rows[r] = stim[r][31:0];
        end
        for (int k = 0; k < `CONV_KERNELS; k++) begin
            for (int r = 0; r < `CONV_K; r++) begin
                for (int c = 0; c < `CONV_K; c++) begin
                    wts[k][r][c] = stim[IMG_ROWS + 8 * k + r][8 * c +: 8];
                end
            end
            biases[k]      = stim[IMG_ROWS + 8 * k + 5][7:0];
            exp_total[k]   = stim[IMG_ROWS + 8 * k + 6][15:0];
            exp_nonzero[k] = int'(stim[IMG_ROWS + 8 * k + 7][15:0]);
        end
        repeat (3) @(posedge sclk);
        s_rst_n <= 1'b1;
        repeat (gap) begin
            @(negedge sclk);
            if (busy !== 1'b0 || conv_rslt_act_vld !== 1'b0) begin
                other_errs++;
                $display("busy or result valid is not low before cal_start at %0t ns", $time);
            end
        end
        run_sweep(1'b1);
        repeat (3) @(posedge sclk);
        run_sweep(1'b0);    // same totals expected again
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // two full runs plus some slack
    always @(posedge sclk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles without finishing", cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

//--- test/conv_stimulus.txt
// 40-bit hex words. words 0-11 are image rows, bit c is column c (28 columns)
// then 8 words per kernel: weight rows 0-4 (byte c is column c), bias, result total, nonzero count
0FFFFFFF    // row 0, all columns set
05555555    // row 1, even columns
00000000    // row 2
01111111    // row 3, every fourth column
0FFFFFFF    // row 4
05555555    // row 5
01111111    // row 6
00000000    // row 7
0FFFFFFF    // row 8
05555555    // row 9
00000000    // row 10
01111111    // row 11
// kernel 0, mixed weights, bias keeps every result positive
0102030201
FF000400FF
05FE01FE05
0003FD0300
FEFF000102
10          // bias 16
12E4        // total 4836
C0          // 192 nonzero
// kernel 1, one weight per row, negative bias clips many windows
0202020202
FDFDFDFDFD
0101010101
FEFEFEFEFE
0303030303
FB          // bias -5
024C        // total 588
3C          // 60 nonzero

//--- all.f
+incdir+hw
hw/conv_pkg.sv
hw/conv_decode.sv
hw/conv_execute.sv
hw/conv_result.sv
hw/conv_top.sv
test/tb_conv.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_conv -f all.f -o tb_conv_sim > sim.log 2>&1 \
    && ./obj_dir/tb_conv_sim >> sim.log 2>&1 \
    || echo "build or simulation error" >> sim.log
cat sim.log
grep -q "Simulation PASSED" sim.log && exit 0 || exit 1
